// ==== logic/crdt_pkg.sv ====
package crdt_pkg;

   // -------------------------------------------------------------------
   // sizes
   // -------------------------------------------------------------------

   // class index order is P = 0, NP = 1, CPL = 2
   localparam int NUM_CLASS  = 3;

   localparam int HDR_CNT_W  = 13;
   localparam int DATA_CNT_W = 16;

   // per-class count fields on the update strobes
   localparam int HDR_UPD_W  = 2;
   localparam int DATA_UPD_W = 4;

   // header length field, in dwords
   localparam int LEN_W      = 10;

   // -------------------------------------------------------------------
   // header type codes
   // -------------------------------------------------------------------

   localparam logic [7:0] TYPE_P_MWR32  = 8'h40;
   localparam logic [7:0] TYPE_P_MWR64  = 8'h60;
   localparam logic [7:0] TYPE_NP_MRD32 = 8'h00;
   localparam logic [7:0] TYPE_NP_MRD64 = 8'h20;
   localparam logic [7:0] TYPE_CPL      = 8'h0A;
   localparam logic [7:0] TYPE_CPLD     = 8'h4A;

   // type bit that says the header carries data
   localparam int PAYLOAD_BIT  = 6;

   // counters below this level hold off the upstream
   localparam int BP_THRESHOLD = 3;

   // -------------------------------------------------------------------
   // types
   // -------------------------------------------------------------------

   typedef logic [HDR_CNT_W-1:0]  hdr_cnt_t;
   typedef logic [DATA_CNT_W-1:0] data_cnt_t;

   typedef struct packed {
      logic [NUM_CLASS-1:0]                vld;
      logic [NUM_CLASS-1:0][HDR_UPD_W-1:0] cnt;
   } hdr_upd_t;

   typedef struct packed {
      logic [NUM_CLASS-1:0]                 vld;
      logic [NUM_CLASS-1:0][DATA_UPD_W-1:0] cnt;
   } data_upd_t;

   // one-hot class plus data credits, all zero when idle
   typedef struct packed {
      logic [NUM_CLASS-1:0] cls;
      logic [LEN_W-2:0]     dcrdt;
   } tlp_evt_t;

   typedef struct packed {
      hdr_cnt_t  [NUM_CLASS-1:0] hdr;
      data_cnt_t [NUM_CLASS-1:0] data;
   } crdt_avail_t;

   typedef struct packed {
      logic [NUM_CLASS-1:0] hdr;
      logic [NUM_CLASS-1:0] data;
   } crdt_inf_t;

endpackage

// ==== logic/tlp_classifier.sv ====
`timescale 1ns/1ns

module tlp_classifier (
   input  logic                          clk,
   input  logic                          srst_reg,
   input  logic                          tx_hdr_valid_i,
   input  logic [crdt_pkg::LEN_W-1:0]    tx_hdr_len_i,
   input  logic [7:0]                    tx_hdr_type_i,
   output crdt_pkg::tlp_evt_t            tlp_evt_o
);

   logic [crdt_pkg::NUM_CLASS-1:0] cls;
   logic [crdt_pkg::LEN_W-2:0]     len_crdt;
   logic [crdt_pkg::LEN_W-2:0]     dcrdt;

   // class decode, unknown types fall through with no class
   always_comb begin
      cls = '0;
      if (tx_hdr_valid_i) begin
         case (tx_hdr_type_i)
            crdt_pkg::TYPE_P_MWR32,
            crdt_pkg::TYPE_P_MWR64:  cls[0] = 1'b1;
            crdt_pkg::TYPE_NP_MRD32,
            crdt_pkg::TYPE_NP_MRD64: cls[1] = 1'b1;
            crdt_pkg::TYPE_CPL,
            crdt_pkg::TYPE_CPLD:     cls[2] = 1'b1;
            default:                 cls = '0;
         endcase
      end
   end

   // dwords to 4-dword credits, rounded up
   assign len_crdt = {1'b0, tx_hdr_len_i[crdt_pkg::LEN_W-1:2]} +
                     {{(crdt_pkg::LEN_W-2){1'b0}}, |tx_hdr_len_i[1:0]};

   // only payload types draw on the data counters
   assign dcrdt = ((|cls) && tx_hdr_type_i[crdt_pkg::PAYLOAD_BIT]) ? len_crdt : '0;

   always_ff @(posedge clk or posedge srst_reg) begin
      if (srst_reg) begin
         tlp_evt_o <= '0;
      end else begin
         tlp_evt_o.cls   <= cls;
         tlp_evt_o.dcrdt <= dcrdt;
      end
   end

endmodule

// ==== logic/crdt_init_ctrl.sv ====
`timescale 1ns/1ns

module crdt_init_ctrl (
   input  logic                            clk,
   input  logic                            srst_reg,
   input  logic [crdt_pkg::NUM_CLASS-1:0]  hcrdt_init_i,
   input  logic [crdt_pkg::NUM_CLASS-1:0]  dcrdt_init_i,
   output logic [crdt_pkg::NUM_CLASS-1:0]  hinit_q_o,
   output logic [crdt_pkg::NUM_CLASS-1:0]  dinit_q_o,
   output logic [crdt_pkg::NUM_CLASS-1:0]  hcrdt_init_ack_o,
   output logic [crdt_pkg::NUM_CLASS-1:0]  dcrdt_init_ack_o
);

   // one replied bit per channel, set once the ack has gone out
   logic [crdt_pkg::NUM_CLASS-1:0] hreplied_q;
   logic [crdt_pkg::NUM_CLASS-1:0] dreplied_q;

   // -------------------------------------------------------------------
   // input capture
   // -------------------------------------------------------------------

   always_ff @(posedge clk or posedge srst_reg) begin
      if (srst_reg) begin
         hinit_q_o <= '0;
         dinit_q_o <= '0;
      end else begin
         hinit_q_o <= hcrdt_init_i;
         dinit_q_o <= dcrdt_init_i;
      end
   end

   // -------------------------------------------------------------------
   // acknowledge per channel
   // -------------------------------------------------------------------

   always_ff @(posedge clk or posedge srst_reg) begin
      if (srst_reg) begin
         hreplied_q       <= '0;
         dreplied_q       <= '0;
         hcrdt_init_ack_o <= '0;
         dcrdt_init_ack_o <= '0;
      end else begin
         for (int i = 0; i < crdt_pkg::NUM_CLASS; i++) begin
            // header channels
            if (hinit_q_o[i]) begin
               hcrdt_init_ack_o[i] <= ~hreplied_q[i];
               hreplied_q[i]       <= 1'b1;
            end else begin
               // init dropped, re-arm for the next request
               hcrdt_init_ack_o[i] <= 1'b0;
               hreplied_q[i]       <= 1'b0;
            end

            // data channels
            if (dinit_q_o[i]) begin
               dcrdt_init_ack_o[i] <= ~dreplied_q[i];
               dreplied_q[i]       <= 1'b1;
            end else begin
               dcrdt_init_ack_o[i] <= 1'b0;
               dreplied_q[i]       <= 1'b0;
            end
         end
      end
   end

endmodule

// ==== logic/crdt_counter.sv ====
`timescale 1ns/1ns

module crdt_counter #(
   parameter type cnt_t = crdt_pkg::hdr_cnt_t
) (
   input  logic                               clk,
   input  logic                               srst_reg,
   input  cnt_t                               consume_i,
   input  logic                               upd_i,
   input  logic [crdt_pkg::DATA_UPD_W-1:0]    upd_cnt_i,
   input  logic                               init_q_i,
   output cnt_t                               count_o,
   output logic                               infinite_o
);

   cnt_t upd_amt;
   logic zero_upd;

   // returned credits, zero when no strobe this cycle
   assign upd_amt = upd_i ? cnt_t'(upd_cnt_i) : '0;

   // a zero-count return during init means no limit on this channel
   assign zero_upd = upd_i && init_q_i && (upd_cnt_i == '0);

   // -------------------------------------------------------------------
   // count
   // -------------------------------------------------------------------

   // consume and return can land together, wraps at the counter width
   always_ff @(posedge clk or posedge srst_reg) begin
      if (srst_reg) begin
         count_o <= '0;
      end else begin
         count_o <= count_o - consume_i + upd_amt;
      end
   end

   // -------------------------------------------------------------------
   // infinite flag
   // -------------------------------------------------------------------

   // sticky until reset
   always_ff @(posedge clk or posedge srst_reg) begin
      if (srst_reg) begin
         infinite_o <= 1'b0;
      end else if (zero_upd) begin
         infinite_o <= 1'b1;
      end
   end

endmodule

// ==== logic/tx_ready_gate.sv ====
`timescale 1ns/1ns

module tx_ready_gate (
   input  logic                   clk,
   input  logic                   srst_reg,
   input  crdt_pkg::crdt_avail_t  avail_i,
   input  crdt_pkg::crdt_inf_t    inf_i,
   input  logic                   pio_ready_i,
   output logic                   tx_ready_o
);

   logic starved;

   // any finite counter under the threshold holds off the upstream
   always_comb begin
      starved = 1'b0;
      for (int i = 0; i < crdt_pkg::NUM_CLASS; i++) begin
         if (!inf_i.hdr[i] &&
             (avail_i.hdr[i] < crdt_pkg::hdr_cnt_t'(crdt_pkg::BP_THRESHOLD))) begin
            starved = 1'b1;
         end
         if (!inf_i.data[i] &&
             (avail_i.data[i] < crdt_pkg::data_cnt_t'(crdt_pkg::BP_THRESHOLD))) begin
            starved = 1'b1;
         end
      end
   end

   // low out of reset, stays low until credits arrive
   always_ff @(posedge clk or posedge srst_reg) begin
      if (srst_reg) begin
         tx_ready_o <= 1'b0;
      end else if (starved) begin
         tx_ready_o <= 1'b0;
      end else begin
         tx_ready_o <= pio_ready_i;
      end
   end

endmodule

// ==== logic/tx_crdt_top.sv ====
`timescale 1ns/1ns

module tx_crdt_top (
   input  logic                            clk,
   input  logic                            srst_reg,
   input  logic                            tx_hdr_valid_i,
   input  logic [crdt_pkg::LEN_W-1:0]      tx_hdr_len_i,
   input  logic [7:0]                      tx_hdr_type_i,
   input  crdt_pkg::hdr_upd_t              hcrdt_upd_i,
   input  crdt_pkg::data_upd_t             dcrdt_upd_i,
   input  logic [crdt_pkg::NUM_CLASS-1:0]  hcrdt_init_i,
   input  logic [crdt_pkg::NUM_CLASS-1:0]  dcrdt_init_i,
   input  logic                            pio_ready_i,
   output logic [crdt_pkg::NUM_CLASS-1:0]  hcrdt_init_ack_o,
   output logic [crdt_pkg::NUM_CLASS-1:0]  dcrdt_init_ack_o,
   output logic                            tx_ready_o,
   output crdt_pkg::crdt_avail_t           crdt_avail_o
);

   crdt_pkg::tlp_evt_t             tlp_evt;
   logic [crdt_pkg::NUM_CLASS-1:0] hinit_q;
   logic [crdt_pkg::NUM_CLASS-1:0] dinit_q;

   // per-counter results, gathered into the structs below
   crdt_pkg::hdr_cnt_t             hdr_cnt  [crdt_pkg::NUM_CLASS];
   crdt_pkg::data_cnt_t            data_cnt [crdt_pkg::NUM_CLASS];
   logic                           hdr_inf  [crdt_pkg::NUM_CLASS];
   logic                           data_inf [crdt_pkg::NUM_CLASS];

   crdt_pkg::crdt_avail_t          crdt_avail;
   crdt_pkg::crdt_inf_t            crdt_inf;

   // -------------------------------------------------------------------
   // header decode and init handshake
   // -------------------------------------------------------------------

   tlp_classifier tlp_classifier_i (
      .clk            (clk),
      .srst_reg       (srst_reg),
      .tx_hdr_valid_i (tx_hdr_valid_i),
      .tx_hdr_len_i   (tx_hdr_len_i),
      .tx_hdr_type_i  (tx_hdr_type_i),
      .tlp_evt_o      (tlp_evt)
   );

   crdt_init_ctrl crdt_init_ctrl_i (
      .clk              (clk),
      .srst_reg         (srst_reg),
      .hcrdt_init_i     (hcrdt_init_i),
      .dcrdt_init_i     (dcrdt_init_i),
      .hinit_q_o        (hinit_q),
      .dinit_q_o        (dinit_q),
      .hcrdt_init_ack_o (hcrdt_init_ack_o),
      .dcrdt_init_ack_o (dcrdt_init_ack_o)
   );

   // -------------------------------------------------------------------
   // counters, one header and one data per class
   // -------------------------------------------------------------------

   for (genvar g = 0; g < crdt_pkg::NUM_CLASS; g++) begin : g_class
      crdt_pkg::hdr_cnt_t                  hdr_consume;
      crdt_pkg::data_cnt_t                 data_consume;
      logic [crdt_pkg::DATA_UPD_W-1:0]     hdr_upd_cnt;

      // one header credit per recognized header of this class
      assign hdr_consume  = crdt_pkg::hdr_cnt_t'(tlp_evt.cls[g]);
      assign data_consume = tlp_evt.cls[g] ? crdt_pkg::data_cnt_t'(tlp_evt.dcrdt) : '0;
      assign hdr_upd_cnt  = {{(crdt_pkg::DATA_UPD_W-crdt_pkg::HDR_UPD_W){1'b0}},
                             hcrdt_upd_i.cnt[g]};

      crdt_counter #(.cnt_t(crdt_pkg::hdr_cnt_t)) hdr_cnt_i (
         .clk        (clk),
         .srst_reg   (srst_reg),
         .consume_i  (hdr_consume),
         .upd_i      (hcrdt_upd_i.vld[g]),
         .upd_cnt_i  (hdr_upd_cnt),
         .init_q_i   (hinit_q[g]),
         .count_o    (hdr_cnt[g]),
         .infinite_o (hdr_inf[g])
      );

      crdt_counter #(.cnt_t(crdt_pkg::data_cnt_t)) data_cnt_i (
         .clk        (clk),
         .srst_reg   (srst_reg),
         .consume_i  (data_consume),
         .upd_i      (dcrdt_upd_i.vld[g]),
         .upd_cnt_i  (dcrdt_upd_i.cnt[g]),
         .init_q_i   (dinit_q[g]),
         .count_o    (data_cnt[g]),
         .infinite_o (data_inf[g])
      );
   end

   always_comb begin
      for (int i = 0; i < crdt_pkg::NUM_CLASS; i++) begin
         crdt_avail.hdr[i]  = hdr_cnt[i];
         crdt_avail.data[i] = data_cnt[i];
         crdt_inf.hdr[i]    = hdr_inf[i];
         crdt_inf.data[i]   = data_inf[i];
      end
   end

   assign crdt_avail_o = crdt_avail;

   // -------------------------------------------------------------------
   // back-pressure
   // -------------------------------------------------------------------

   tx_ready_gate tx_ready_gate_i (
      .clk         (clk),
      .srst_reg    (srst_reg),
      .avail_i     (crdt_avail),
      .inf_i       (crdt_inf),
      .pio_ready_i (pio_ready_i),
      .tx_ready_o  (tx_ready_o)
   );

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
   parameter int PERIOD     = 8,
   parameter int RST_CYCLES = 2
) (
   output logic clk,
   output logic srst_reg
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // reset covers the first rising edges, released just after the last one
   initial begin
      srst_reg = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      #1 srst_reg = 1'b0;
   end

endmodule

// ==== sim/tx_crdt_tb.sv ====
`timescale 1ns/1ns

module tx_crdt_tb;

   localparam int CLK_PERIOD   = 8;
   localparam int THR          = 3;
   localparam int N_CONS       = 200;
   localparam int N_RET        = 24;
   localparam int N_INIT       = 120;
   localparam int N_INF        = 60;
   localparam int N_READY      = 200;
   localparam int TOTAL_CYCLES = 4 + N_CONS + N_RET + N_INIT + N_INF + N_READY;

   // stimulus profiles
   localparam int M_RET   = 0;
   localparam int M_CONS  = 1;
   localparam int M_INIT  = 2;
   localparam int M_INF   = 3;
   localparam int M_READY = 4;

   logic                       clk;
   logic                       srst_reg;
   logic                       tx_hdr_valid;
   logic [crdt_pkg::LEN_W-1:0] tx_hdr_len;
   logic [7:0]                 tx_hdr_type;
   crdt_pkg::hdr_upd_t         hupd;
   crdt_pkg::data_upd_t        dupd;
   logic [2:0]                 hinit;
   logic [2:0]                 dinit;
   logic                       pio_ready;
   logic [2:0]                 hack;
   logic [2:0]                 dack;
   logic                       tx_ready;
   crdt_pkg::crdt_avail_t      avail;

   // ---------------------------------------------------------------------
   // reference model state
   // ---------------------------------------------------------------------
   crdt_pkg::hdr_cnt_t  m_hdr  [crdt_pkg::NUM_CLASS];
   crdt_pkg::data_cnt_t m_data [crdt_pkg::NUM_CLASS];
   logic [2:0]          m_hinf;
   logic [2:0]          m_dinf;
   logic [2:0]          m_hinit_q;
   logic [2:0]          m_dinit_q;
   logic [2:0]          m_hrep;
   logic [2:0]          m_drep;
   logic [2:0]          m_hack;
   logic [2:0]          m_dack;
   logic                m_ready;
   logic [2:0]          m_evt_cls;
   logic [8:0]          m_evt_dcrdt;

   integer seed = 32'h28d9;
   int     errors;
   int     tests_pass;
   int     tests_fail;

   tb_clk_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(2)) tb_clk_gen_i (
      .clk      (clk),
      .srst_reg (srst_reg)
   );

   tx_crdt_top tx_crdt_top_i (
      .clk              (clk),
      .srst_reg         (srst_reg),
      .tx_hdr_valid_i   (tx_hdr_valid),
      .tx_hdr_len_i     (tx_hdr_len),
      .tx_hdr_type_i    (tx_hdr_type),
      .hcrdt_upd_i      (hupd),
      .dcrdt_upd_i      (dupd),
      .hcrdt_init_i     (hinit),
      .dcrdt_init_i     (dinit),
      .pio_ready_i      (pio_ready),
      .hcrdt_init_ack_o (hack),
      .dcrdt_init_ack_o (dack),
      .tx_ready_o       (tx_ready),
      .crdt_avail_o     (avail)
   );

   function automatic logic [31:0] next_rand();
      return $random(seed);
   endfunction

   // six known codes, the rest mostly unknown
   function automatic logic [7:0] pick_type(input logic [31:0] r);
      case (r[2:0])
         3'd0:    return 8'h40;
         3'd1:    return 8'h60;
         3'd2:    return 8'h00;
         3'd3:    return 8'h20;
         3'd4:    return 8'h0A;
         3'd5:    return 8'h4A;
         default: return r[15:8];
      endcase
   endfunction

   function automatic logic [2:0] class_of(input logic [7:0] t);
      case (t)
         8'h40, 8'h60: return 3'b001;
         8'h00, 8'h20: return 3'b010;
         8'h0A, 8'h4A: return 3'b100;
         default:      return 3'b000;
      endcase
   endfunction

   task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
         errors++;
      end
   endtask

   task automatic check_outputs();
      for (int c = 0; c < crdt_pkg::NUM_CLASS; c++) begin
         check_hex($sformatf("crdt_avail_o.hdr[%0d]", c), 32'(avail.hdr[c]), 32'(m_hdr[c]));
         check_hex($sformatf("crdt_avail_o.data[%0d]", c), 32'(avail.data[c]), 32'(m_data[c]));
      end
      check_hex("hcrdt_init_ack_o", 32'(hack), 32'(m_hack));
      check_hex("dcrdt_init_ack_o", 32'(dack), 32'(m_dack));
      check_hex("tx_ready_o", 32'(tx_ready), 32'(m_ready));
   endtask

   // advance the model by one rising edge with the inputs now applied
   task automatic model_step();
      logic starved;
      starved = 1'b0;
      for (int c = 0; c < crdt_pkg::NUM_CLASS; c++) begin
         if (!m_hinf[c] && (m_hdr[c] < 13'(THR))) starved = 1'b1;
         if (!m_dinf[c] && (m_data[c] < 16'(THR))) starved = 1'b1;
      end
      m_ready = starved ? 1'b0 : pio_ready;
      for (int c = 0; c < crdt_pkg::NUM_CLASS; c++) begin
         if (hupd.vld[c] && m_hinit_q[c] && (hupd.cnt[c] == '0)) m_hinf[c] = 1'b1;
         if (dupd.vld[c] && m_dinit_q[c] && (dupd.cnt[c] == '0)) m_dinf[c] = 1'b1;
         m_hdr[c]  = m_hdr[c] - 13'(m_evt_cls[c]) +
                     (hupd.vld[c] ? 13'(hupd.cnt[c]) : 13'd0);
         m_data[c] = m_data[c] - (m_evt_cls[c] ? 16'(m_evt_dcrdt) : 16'd0) +
                     (dupd.vld[c] ? 16'(dupd.cnt[c]) : 16'd0);
      end
      m_hack    = m_hinit_q & ~m_hrep;
      m_dack    = m_dinit_q & ~m_drep;
      m_hrep    = m_hinit_q;
      m_drep    = m_dinit_q;
      m_hinit_q = hinit;
      m_dinit_q = dinit;
      // data credits are the dword length rounded up to groups of four
      m_evt_cls   = tx_hdr_valid ? class_of(tx_hdr_type) : 3'b000;
      m_evt_dcrdt = ((m_evt_cls != 3'b000) && tx_hdr_type[6]) ?
                    9'((11'(tx_hdr_len) + 11'd3) >> 2) : 9'd0;
   endtask

   task automatic drive_inputs(input int mode);
      logic [31:0] r0;
      logic [31:0] r1;
      logic [31:0] r2;
      r0 = next_rand();
      r1 = next_rand();
      r2 = next_rand();
      tx_hdr_valid = 1'b0;
      tx_hdr_type  = pick_type(r0);
      tx_hdr_len   = r0[25:16];
      hupd         = r1[8:0];
      dupd         = r2[14:0];
      pio_ready    = r2[31];
      case (mode)
         M_CONS, M_READY: begin
            // sparse header returns so the header counters drift around zero
            tx_hdr_valid = r0[8] | r0[9];
            hupd.vld     = r1[11:9] & r1[14:12] & r1[17:15];
            if (mode == M_READY) hupd.vld &= r1[20:18];
            hinit = 3'b000;
            dinit = 3'b000;
         end
         M_INIT: begin
            hupd  = '0;
            dupd  = '0;
            hinit = hinit ^ (r1[2:0] & r1[5:3] & r1[8:6]);
            dinit = dinit ^ (r2[2:0] & r2[5:3] & r2[8:6]);
         end
         M_INF: begin
            hinit = 3'b101;
            dinit = 3'b010;
            for (int c = 0; c < crdt_pkg::NUM_CLASS; c++) begin
               // channels in init only see zero counts and stay empty
               if (hinit[c]) hupd.cnt[c] = '0;
               if (dinit[c]) dupd.cnt[c] = '0;
               // the other channels climb just past the threshold and stop
               if (!hinit[c] && (m_hdr[c] >= 13'(THR))) hupd.vld[c] = 1'b0;
               if (!dinit[c] && (m_data[c] >= 16'(THR))) dupd.vld[c] = 1'b0;
            end
         end
         default: begin
         end
      endcase
   endtask

   task automatic report_test(input string name, input int cycles);
      if (errors == 0) begin
         tests_pass++;
         $display("test %s: ok after %0d cycles", name, cycles);
      end else begin
         tests_fail++;
         $display("test %s: %0d errors in %0d cycles", name, errors, cycles);
      end
   endtask

   task automatic run_test(input string name, input int mode, input int cycles);
      errors = 0;
      repeat (cycles) begin
         @(posedge clk);
         #1;
         check_outputs();
         drive_inputs(mode);
         model_step();
      end
      report_test(name, cycles);
   endtask

   // ---------------------------------------------------------------------
   // main sequence
   // ---------------------------------------------------------------------
   initial begin
      tx_hdr_valid = 1'b0;
      tx_hdr_len   = '0;
      tx_hdr_type  = '0;
      hupd         = '0;
      dupd         = '0;
      hinit        = '0;
      dinit        = '0;
      pio_ready    = 1'b0;
      for (int c = 0; c < crdt_pkg::NUM_CLASS; c++) begin
         m_hdr[c]  = '0;
         m_data[c] = '0;
      end
      {m_hinf, m_dinf, m_hinit_q, m_dinit_q} = '0;
      {m_hrep, m_drep, m_hack, m_dack} = '0;
      {m_ready, m_evt_cls, m_evt_dcrdt} = '0;
      tests_pass = 0;
      tests_fail = 0;

      @(negedge srst_reg);
      errors = 0;
      check_outputs();
      report_test("reset state", 0);

      // flags go first, while the counters in init are still empty
      run_test("infinite flags", M_INF, N_INF);
      run_test("consumption", M_CONS, N_CONS);
      run_test("credit returns", M_RET, N_RET);
      run_test("init acknowledge", M_INIT, N_INIT);
      run_test("ready gating", M_READY, N_READY);

      // last edge of the final test
      @(posedge clk);
      #1;
      errors = 0;
      check_outputs();
      if (errors != 0) tests_fail++;

      $display("tests passed %0d failed %0d", tests_pass, tests_fail);
      if (tests_fail == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      #(TOTAL_CYCLES * CLK_PERIOD + 100);
      $display("watchdog expired after %0d ns, the run did not finish", $time);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// ==== tx_crdt_top.f ====
logic/crdt_pkg.sv
logic/tlp_classifier.sv
logic/crdt_init_ctrl.sv
logic/crdt_counter.sv
logic/tx_ready_gate.sv
logic/tx_crdt_top.sv
sim/tb_clk_gen.sv
sim/tx_crdt_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then decide on the pass line in the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tx_crdt_tb \
   -f tx_crdt_top.f -o tx_crdt_sim > "$LOG" 2>&1 &&
   ./obj_dir/tx_crdt_sim >> "$LOG" 2>&1
cat "$LOG"
grep -qx "TEST RESULT: PASS" "$LOG" && echo "simulation passed" ||
   { echo "simulation failed"; exit 1; }
